// ==== hw/eth_pkg.sv ====
package eth_pkg;

   // CPU port and frame buffer geometry
   localparam int ETH_ADDR_W = 12;
   localparam int ETH_BUF_AW = 11;
   localparam int ETH_CNT_W  = 12;

   // Register defaults and PHY reset hold
   localparam logic [ETH_BUF_AW-1:0] ETH_NBYTES_RST = 11'd46;
   localparam int ETH_PHY_RST_CYCLES = 255;
   localparam int ETH_PHY_CNT_W = $clog2(ETH_PHY_RST_CYCLES + 1);

   // Register word addresses below the bit 11 data region
   localparam logic [ETH_ADDR_W-1:0] ETH_REG_STATUS    = 12'd0;
   localparam logic [ETH_ADDR_W-1:0] ETH_REG_DUMMY     = 12'd1;
   localparam logic [ETH_ADDR_W-1:0] ETH_REG_SEND      = 12'd2;
   localparam logic [ETH_ADDR_W-1:0] ETH_REG_TX_NBYTES = 12'd3;
   localparam logic [ETH_ADDR_W-1:0] ETH_REG_SOFTRST   = 12'd4;

   // Frame layout in nibbles
   localparam int ETH_PREAMBLE_NIB = 15;
   localparam int ETH_FCS_NIB = 8;
   localparam logic [3:0] ETH_PREAMBLE_VAL = 4'h5;
   localparam logic [3:0] ETH_SFD_VAL = 4'hD;

   // Reflected CRC-32 polynomial
   localparam logic [31:0] ETH_CRC_POLY = 32'hEDB8_8320;

   typedef enum logic [2:0] {
      ST_IDLE,
      ST_PREAMBLE,
      ST_SFD,
      ST_PAYLOAD,
      ST_FCS
   } eth_tx_state_t;

endpackage

// ==== hw/eth_csr.sv ====
`timescale 1ns/100ps

module eth_csr (
   input  logic                            clk,
   input  logic                            rst_int,
   input  logic                            valid,
   input  logic                            wstrb,
   input  logic [eth_pkg::ETH_ADDR_W-1:0]  addr,
   input  logic [31:0]                     data_in,
   output logic                            ready,
   output logic [31:0]                     data_out,
   input  logic                            busy,
   output logic                            buf_we,
   output logic [eth_pkg::ETH_BUF_AW-1:0]  buf_waddr,
   output logic [7:0]                      buf_wdata,
   output logic [eth_pkg::ETH_BUF_AW-1:0]  nbytes,
   output logic                            send_pulse,
   output logic                            soft_clr,
   output logic                            phy_resetn
);
   import eth_pkg::*;

   logic                     wr;
   logic [31:0]              dummy;
   logic [31:0]              rd_data;
   logic [ETH_PHY_CNT_W-1:0] phy_cnt;

   assign wr = valid && wstrb;

   // Byte writes into the frame buffer
   assign buf_we    = wr && addr[ETH_ADDR_W-1];
   assign buf_waddr = addr[ETH_BUF_AW-1:0];
   assign buf_wdata = data_in[7:0];

   // Send only once the PHY is out of reset and no frame is running
   assign send_pulse = wr && (addr == ETH_REG_SEND) && phy_resetn && !busy;

   always_ff @(posedge clk or posedge rst_int) begin
      if (rst_int) begin
         soft_clr <= 1'b0;
      end else begin
         soft_clr <= wr && (addr == ETH_REG_SOFTRST);
      end
   end

   always_ff @(posedge clk or posedge rst_int) begin
      if (rst_int) begin
         dummy  <= '0;
         nbytes <= ETH_NBYTES_RST;
      end else if (soft_clr) begin
         dummy  <= '0;
         nbytes <= ETH_NBYTES_RST;
      end else if (wr && addr == ETH_REG_DUMMY) begin
         dummy <= data_in;
      end else if (wr && addr == ETH_REG_TX_NBYTES) begin
         nbytes <= data_in[ETH_BUF_AW-1:0];
      end
   end

   // PHY held in reset until the counter saturates
   always_ff @(posedge clk or posedge rst_int) begin
      if (rst_int) begin
         phy_cnt    <= '0;
         phy_resetn <= 1'b0;
      end else if (soft_clr) begin
         phy_cnt    <= '0;
         phy_resetn <= 1'b0;
      end else if (phy_cnt != ETH_PHY_CNT_W'(ETH_PHY_RST_CYCLES)) begin
         phy_cnt <= phy_cnt + 1'b1;
      end else begin
         phy_resetn <= 1'b1;
      end
   end

   always_comb begin
      case (addr)
         ETH_REG_STATUS: rd_data = {30'd0, phy_resetn, phy_resetn && !busy};
         ETH_REG_DUMMY:  rd_data = dummy;
         default:        rd_data = '0;
      endcase
   end

   // Read data lands in the same cycle as ready
   always_ff @(posedge clk or posedge rst_int) begin
      if (rst_int) begin
         ready    <= 1'b0;
         data_out <= '0;
      end else begin
         ready    <= valid;
         data_out <= valid ? rd_data : '0;
      end
   end

   // The transmitter goes busy the cycle after an accepted send
   a_send_when_idle: assert property (
      @(posedge clk) disable iff (rst_int)
      send_pulse |=> busy
   );

endmodule

// ==== hw/eth_tx_fsm.sv ====
`timescale 1ns/100ps

module eth_tx_fsm (
   input  logic                            clk,
   input  logic                            rst_int,
   input  logic                            send_pulse,
   input  logic [eth_pkg::ETH_BUF_AW-1:0]  nbytes,
   input  logic [eth_pkg::ETH_CNT_W-1:0]   cnt,
   input  logic                            cnt_last,
   output logic                            cnt_clr,
   output logic [eth_pkg::ETH_CNT_W-1:0]   cnt_limit,
   output logic [eth_pkg::ETH_BUF_AW-1:0]  buf_raddr,
   input  logic [7:0]                      buf_rdata,
   output logic                            crc_init,
   output logic                            crc_en,
   output logic                            crc_shift,
   input  logic [3:0]                      fcs_nib,
   output logic                            busy,
   output logic                            tx_en,
   output logic [3:0]                      tx_data
);
   import eth_pkg::*;

   eth_tx_state_t         state;
   eth_tx_state_t         state_nxt;
   logic [ETH_BUF_AW-1:0] nbytes_q;

   // Length is sampled at send so CPU writes mid-frame do no harm
   always_ff @(posedge clk) begin
      if (state == ST_IDLE && send_pulse) begin
         nbytes_q <= nbytes;
      end
   end

   always_ff @(posedge clk or posedge rst_int) begin
      if (rst_int) begin
         state <= ST_IDLE;
      end else begin
         state <= state_nxt;
      end
   end

   always_comb begin
      state_nxt = state;
      case (state)
         ST_IDLE:     if (send_pulse) state_nxt = ST_PREAMBLE;
         ST_PREAMBLE: if (cnt_last) state_nxt = ST_SFD;
         // Empty payload goes straight to the FCS
         ST_SFD:      state_nxt = (nbytes_q == '0) ? ST_FCS : ST_PAYLOAD;
         ST_PAYLOAD:  if (cnt_last) state_nxt = ST_FCS;
         ST_FCS:      if (cnt_last) state_nxt = ST_IDLE;
         default:     state_nxt = ST_IDLE;
      endcase
   end

   always_comb begin
      case (state)
         ST_PREAMBLE: cnt_limit = ETH_CNT_W'(ETH_PREAMBLE_NIB - 1);
         ST_PAYLOAD:  cnt_limit = {nbytes_q, 1'b0} - 1'b1;
         ST_FCS:      cnt_limit = ETH_CNT_W'(ETH_FCS_NIB - 1);
         default:     cnt_limit = '0;
      endcase
   end

   assign cnt_clr   = (state == ST_IDLE) || cnt_last;
   assign buf_raddr = cnt[ETH_CNT_W-1:1];
   assign crc_init  = (state == ST_IDLE);
   assign crc_en    = (state == ST_PAYLOAD);
   assign crc_shift = (state == ST_FCS);
   assign busy      = (state != ST_IDLE);
   assign tx_en     = (state != ST_IDLE);

   always_comb begin
      case (state)
         ST_PREAMBLE: tx_data = ETH_PREAMBLE_VAL;
         ST_SFD:      tx_data = ETH_SFD_VAL;
         // Low nibble on even count
         ST_PAYLOAD:  tx_data = cnt[0] ? buf_rdata[7:4] : buf_rdata[3:0];
         ST_FCS:      tx_data = fcs_nib;
         default:     tx_data = 4'h0;
      endcase
   end

   // Counter parked at zero whenever the port is quiet
   a_idle_quiet: assert property (
      @(posedge clk) disable iff (rst_int)
      !tx_en |-> (cnt == '0)
   );

endmodule

// ==== hw/eth_tx_cnt.sv ====
`timescale 1ns/100ps

module eth_tx_cnt (
   input  logic                          clk,
   input  logic                          rst_int,
   input  logic                          cnt_clr,
   input  logic [eth_pkg::ETH_CNT_W-1:0] cnt_limit,
   output logic [eth_pkg::ETH_CNT_W-1:0] cnt,
   output logic                          cnt_last
);

   // Free running within a phase, restarted on each phase change
   always_ff @(posedge clk or posedge rst_int) begin
      if (rst_int) begin
         cnt <= '0;
      end else if (cnt_clr) begin
         cnt <= '0;
      end else begin
         cnt <= cnt + 1'b1;
      end
   end

   assign cnt_last = (cnt == cnt_limit);

   // Limit comes from the FSM and must be reloaded in step with the clear
   a_cnt_in_range: assert property (
      @(posedge clk) disable iff (rst_int)
      cnt <= cnt_limit
   );

endmodule

// ==== hw/eth_tx_buf.sv ====
`timescale 1ns/100ps

module eth_tx_buf (
   input  logic                           clk,
   input  logic                           we,
   input  logic [eth_pkg::ETH_BUF_AW-1:0] waddr,
   input  logic [7:0]                     wdata,
   input  logic [eth_pkg::ETH_BUF_AW-1:0] raddr,
   output logic [7:0]                     rdata
);
   import eth_pkg::*;

   logic [7:0] mem [0:(2**ETH_BUF_AW)-1];

   // CPU side write port
   always_ff @(posedge clk) begin
      if (we) begin
         mem[waddr] <= wdata;
      end
   end

   // Transmit side read, no latency
   assign rdata = mem[raddr];

endmodule

// ==== hw/eth_crc32.sv ====
`timescale 1ns/100ps

module eth_crc32 (
   input  logic       clk,
   input  logic       rst_int,
   input  logic       crc_init,
   input  logic       crc_en,
   input  logic       crc_shift,
   input  logic [3:0] nib,
   output logic [3:0] fcs_nib
);
   import eth_pkg::*;

   logic [31:0] crc_q;
   logic [31:0] crc_nxt;

   // Four reflected steps, LSB of the nibble first
   always_comb begin
      crc_nxt = crc_q;
      for (int i = 0; i < 4; i++) begin
         if (crc_nxt[0] ^ nib[i]) begin
            crc_nxt = (crc_nxt >> 1) ^ ETH_CRC_POLY;
         end else begin
            crc_nxt = crc_nxt >> 1;
         end
      end
   end

   always_ff @(posedge clk or posedge rst_int) begin
      if (rst_int) begin
         crc_q <= '1;
      end else if (crc_init) begin
         crc_q <= '1;
      end else if (crc_en) begin
         crc_q <= crc_nxt;
      end else if (crc_shift) begin
         // Next FCS nibble moves into the low bits
         crc_q <= {4'hF, crc_q[31:4]};
      end
   end

   assign fcs_nib = ~crc_q[3:0];

endmodule

// ==== hw/eth_core.sv ====
`timescale 1ns/100ps

module eth_core (
   input  logic                           clk,
   input  logic                           rst_int,
   input  logic                           valid,
   input  logic                           wstrb,
   input  logic [eth_pkg::ETH_ADDR_W-1:0] addr,
   input  logic [31:0]                    data_in,
   output logic                           ready,
   output logic [31:0]                    data_out,
   output logic                           phy_resetn,
   output logic                           tx_en,
   output logic [3:0]                     tx_data
);
   import eth_pkg::*;

   logic                  busy;
   logic                  send_pulse;
   logic                  buf_we;
   logic [ETH_BUF_AW-1:0] buf_waddr;
   logic [7:0]            buf_wdata;
   logic [ETH_BUF_AW-1:0] buf_raddr;
   logic [7:0]            buf_rdata;
   logic [ETH_BUF_AW-1:0] nbytes;
   logic [ETH_CNT_W-1:0]  cnt;
   logic [ETH_CNT_W-1:0]  cnt_limit;
   logic                  cnt_clr;
   logic                  cnt_last;
   logic                  crc_init;
   logic                  crc_en;
   logic                  crc_shift;
   logic [3:0]            fcs_nib;

   eth_csr u_csr (
      .clk        (clk),
      .rst_int    (rst_int),
      .valid      (valid),
      .wstrb      (wstrb),
      .addr       (addr),
      .data_in    (data_in),
      .ready      (ready),
      .data_out   (data_out),
      .busy       (busy),
      .buf_we     (buf_we),
      .buf_waddr  (buf_waddr),
      .buf_wdata  (buf_wdata),
      .nbytes     (nbytes),
      .send_pulse (send_pulse),
      .soft_clr   (),
      .phy_resetn (phy_resetn)
   );

   eth_tx_fsm u_fsm (
      .clk        (clk),
      .rst_int    (rst_int),
      .send_pulse (send_pulse),
      .nbytes     (nbytes),
      .cnt        (cnt),
      .cnt_last   (cnt_last),
      .cnt_clr    (cnt_clr),
      .cnt_limit  (cnt_limit),
      .buf_raddr  (buf_raddr),
      .buf_rdata  (buf_rdata),
      .crc_init   (crc_init),
      .crc_en     (crc_en),
      .crc_shift  (crc_shift),
      .fcs_nib    (fcs_nib),
      .busy       (busy),
      .tx_en      (tx_en),
      .tx_data    (tx_data)
   );

   eth_tx_cnt u_cnt (
      .clk       (clk),
      .rst_int   (rst_int),
      .cnt_clr   (cnt_clr),
      .cnt_limit (cnt_limit),
      .cnt       (cnt),
      .cnt_last  (cnt_last)
   );

   eth_tx_buf u_buf (
      .clk   (clk),
      .we    (buf_we),
      .waddr (buf_waddr),
      .wdata (buf_wdata),
      .raddr (buf_raddr),
      .rdata (buf_rdata)
   );

   // CRC folds the payload nibbles as they go out on the MII port
   eth_crc32 u_crc (
      .clk       (clk),
      .rst_int   (rst_int),
      .crc_init  (crc_init),
      .crc_en    (crc_en),
      .crc_shift (crc_shift),
      .nib       (tx_data),
      .fcs_nib   (fcs_nib)
   );

endmodule

// ==== tests/tb_eth_core.sv ====
`timescale 1ns/100ps

module tb_eth_core;
   import eth_pkg::*;

   logic        clk;
   logic        rst_int;
   logic        valid;
   logic        wstrb;
   logic [11:0] addr;
   logic [31:0] data_in;
   logic        ready;
   logic [31:0] data_out;
   logic        phy_resetn;
   logic        tx_en;
   logic [3:0]  tx_data;

   integer      seed;
   int          errors;
   int          checks;
   int          frames;
   logic        tx_en_d;
   logic [31:0] rdata;
   logic [7:0]  buf_model [0:2047];
   logic [3:0]  nib_q [$];

   eth_core u_dut (
      .clk        (clk),
      .rst_int    (rst_int),
      .valid      (valid),
      .wstrb      (wstrb),
      .addr       (addr),
      .data_in    (data_in),
      .ready      (ready),
      .data_out   (data_out),
      .phy_resetn (phy_resetn),
      .tx_en      (tx_en),
      .tx_data    (tx_data)
   );

   always #2 clk = ~clk;

   // MII capture on the falling edge with one nibble per tx_en cycle
   always @(negedge clk) begin
      if (tx_en === 1'b1) begin
         if (!tx_en_d) begin
            nib_q.delete();
         end
         nib_q.push_back(tx_data);
      end else if (tx_en_d) begin
         frames++;
      end
      tx_en_d = (tx_en === 1'b1);
   end

   // Reflected CRC-32 taken one bit at a time from the LSB of each byte
   function automatic logic [31:0] fcs_of(input int n);
      logic [31:0] crc;
      crc = 32'hFFFF_FFFF;
      for (int i = 0; i < n; i++) begin
         for (int b = 0; b < 8; b++) begin
            if (crc[0] ^ buf_model[i][b]) begin
               crc = (crc >> 1) ^ 32'hEDB8_8320;
            end else begin
               crc = crc >> 1;
            end
         end
      end
      return ~crc;
   endfunction

   task automatic compare(input string name, input logic [31:0] got, input logic [31:0] exp);
      checks++;
      if (got !== exp) begin
         errors++;
         $display("error at %0t ns: %s got %h expected %h", $time, name, got, exp);
      end
   endtask

   task automatic stop_on_timeout(input string msg);
      errors++;
      $display("timeout: %s", msg);
      $display("closing: %0d checks, %0d errors", checks, errors);
      $display("=== FAIL ===");
      $finish;
   endtask

   // One CPU cycle with valid held for a single clock and the result left in rdata
   task automatic bus_access(input logic we, input logic [11:0] a, input logic [31:0] d);
      int n;
      @(negedge clk);
      valid   = 1'b1;
      wstrb   = we;
      addr    = a;
      data_in = d;
      @(negedge clk);
      valid = 1'b0;
      wstrb = 1'b0;
      n = 0;
      while (ready !== 1'b1 && n < 16) begin
         @(negedge clk);
         n++;
      end
      if (ready !== 1'b1) begin
         stop_on_timeout("CPU access got no ready");
      end else begin
         compare("ready_delay", n, 0);
         rdata = data_out;
      end
   endtask

   task automatic load_payload(input int n);
      logic [7:0] b;
      for (int i = 0; i < n; i++) begin
         b = 8'($random(seed));
         buf_model[i] = b;
         bus_access(1'b1, 12'h800 | 12'(i), {24'd0, b});
      end
   endtask

   task automatic phy_level_wait(input logic level);
      int n;
      n = 0;
      while (phy_resetn !== level && n < 400) begin
         @(negedge clk);
         n++;
      end
      if (phy_resetn !== level) begin
         stop_on_timeout("phy_resetn never reached the expected level");
      end
   endtask

   task automatic frame_wait(input int start);
      int n;
      n = 0;
      while (frames == start && n < 1000) begin
         @(negedge clk);
         n++;
      end
      if (frames == start) begin
         $display("FSM in state %s", u_dut.u_fsm.state.name());
         stop_on_timeout("frame did not finish");
      end
   endtask

   task automatic check_frame(input int n);
      logic [31:0] fcs;
      fcs = fcs_of(n);
      compare("tx_en_cycles", nib_q.size(), 16 + 2 * n + 8);
      if (nib_q.size() == 16 + 2 * n + 8) begin
         for (int i = 0; i < 15; i++) begin
            compare("preamble", nib_q[i], 4'h5);
         end
         compare("sfd", nib_q[15], 4'hD);
         for (int i = 0; i < n; i++) begin
            compare("payload_lo", nib_q[16 + 2 * i], buf_model[i][3:0]);
            compare("payload_hi", nib_q[17 + 2 * i], buf_model[i][7:4]);
         end
         for (int k = 0; k < 8; k++) begin
            compare("fcs", nib_q[16 + 2 * n + k], fcs[4 * k +: 4]);
         end
      end
   endtask

   task automatic send_and_check(input int n, input bit poke);
      int start;
      start = frames;
      bus_access(1'b1, ETH_REG_SEND, 32'd1);
      if (poke) begin
         // Second send lands mid-frame
         bus_access(1'b1, ETH_REG_SEND, 32'd1);
         bus_access(1'b0, ETH_REG_STATUS, 32'd0);
         compare("status_busy", rdata, 32'h2);
      end
      frame_wait(start);
      if (frames != start) begin
         check_frame(n);
      end
      if (poke) begin
         repeat (40) @(negedge clk);
         compare("frame_count", frames, start + 1);
         bus_access(1'b0, ETH_REG_STATUS, 32'd0);
         compare("status_idle", rdata, 32'h3);
      end
   endtask

   initial begin
      int          n;
      logic [31:0] v;
      clk     = 1'b0;
      rst_int = 1'b1;
      valid   = 1'b0;
      wstrb   = 1'b0;
      addr    = '0;
      data_in = '0;
      seed    = 32'h93cc_7b55;
      errors  = 0;
      checks  = 0;
      frames  = 0;
      tx_en_d = 1'b0;
      repeat (8) @(negedge clk);
      rst_int = 1'b0;

      // PHY still in reset, so this send is dropped
      compare("phy_resetn", phy_resetn, 1'b0);
      bus_access(1'b0, ETH_REG_STATUS, 32'd0);
      compare("status_reset", rdata, 32'h0);
      bus_access(1'b1, ETH_REG_SEND, 32'd1);
      load_payload(64);
      phy_level_wait(1'b1);
      compare("frames_before_phy", frames, 0);
      bus_access(1'b0, ETH_REG_STATUS, 32'd0);
      compare("status_phy_up", rdata, 32'h3);

      for (int i = 0; i < 4; i++) begin
         v = $random(seed);
         bus_access(1'b1, ETH_REG_DUMMY, v);
         bus_access(1'b0, ETH_REG_DUMMY, 32'd0);
         compare("dummy", rdata, v);
      end

      // Random frames where the last one also gets a send while busy
      for (int i = 0; i < 4; i++) begin
         n = 1 + ($unsigned($random(seed)) % 64);
         load_payload(n);
         bus_access(1'b1, ETH_REG_TX_NBYTES, n);
         send_and_check(n, i == 3);
      end

      // Nonzero scratch and a length other than 46 ahead of the soft reset
      bus_access(1'b1, ETH_REG_DUMMY, 32'hA5A5_5A5A);
      bus_access(1'b1, ETH_REG_TX_NBYTES, 32'd12);

      // Soft reset keeps the buffer and restores the 46 byte length
      bus_access(1'b1, ETH_REG_SOFTRST, 32'd1);
      phy_level_wait(1'b0);
      bus_access(1'b0, ETH_REG_DUMMY, 32'd0);
      compare("dummy_cleared", rdata, 32'h0);
      bus_access(1'b0, ETH_REG_STATUS, 32'd0);
      compare("status_softrst", rdata, 32'h0);
      phy_level_wait(1'b1);
      send_and_check(46, 1'b0);

      $display("closing: %0d checks, %0d errors", checks, errors);
      if (errors == 0) begin
         $display("=== PASS ===");
      end else begin
         $display("=== FAIL ===");
      end
      $finish;
   end

endmodule

// ==== verilog.f ====
hw/eth_pkg.sv
hw/eth_csr.sv
hw/eth_tx_fsm.sv
hw/eth_tx_cnt.sv
hw/eth_tx_buf.sv
hw/eth_crc32.sv
hw/eth_core.sv
tests/tb_eth_core.sv

// ==== run.sh ====
#!/bin/sh
# Build and run the Ethernet MII transmit testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
   --top-module tb_eth_core -f verilog.f -o sim_eth_core

out=$(./obj_dir/sim_eth_core)
echo "$out"

if echo "$out" | grep -qx "=== PASS ==="; then
   exit 0
fi
exit 1
